/* mcontr_cfg.svh */
// size macros for the DDR3 command sequence subsystem
`ifndef MCONTR_CFG_SVH
`define MCONTR_CFG_SVH

`define MCONTR_ADDR_BITS  15 // row / column address width
`define MCONTR_COL_BITS   10 // column bits, 3 LSBs dropped per burst of 8
`define MCONTR_XFER_BITS  6  // burst count, 0 means a full 64
`define MCONTR_PAUSE_BITS 10 // pause length field in a skip word
`define MCONTR_SEQ_DEPTH  64 // sequence memory entries
`define MCONTR_SEQ_AW     6  // sequence memory address width

`endif

/* mcontr_pkg.sv */
// rcw codes, command and pause word forms, command word union, transfer and encoder structs
`include "mcontr_cfg.svh"

package mcontr_pkg;

    typedef enum logic [2:0] {
        RCW_NOP       = 3'd0,
        RCW_READ      = 3'd2,
        RCW_WRITE     = 3'd3,
        RCW_ACTIVATE  = 3'd4,
        RCW_PRECHARGE = 3'd5
    } rcw_t; // RAS/CAS/WE in positive logic

    typedef struct packed {
        logic [`MCONTR_ADDR_BITS-1:0] addr; // row or column address
        logic [2:0]                   bank;
        rcw_t                         rcw;
        logic                         odt_en;
        logic                         cke;
        logic                         sel;        // which half-cycle carries the command
        logic                         dq_en;
        logic                         dqs_en;
        logic                         dqs_toggle;
        logic                         dci;
        logic                         buf_wr;     // page buffer write strobe
        logic                         buf_rd;     // page buffer read strobe
        logic                         nop;        // append a NOP after this command
        logic                         buf_rst;    // advance to the next buffer page
    } cmd_fields_t;

    // pause form shares bank and control positions with the command form
    typedef struct packed {
        logic [`MCONTR_ADDR_BITS-`MCONTR_PAUSE_BITS-2:0] pad;
        logic [`MCONTR_PAUSE_BITS-1:0]                   skip; // extra cycles to hold
        logic                                            done; // end of sequence
        logic [2:0]                                      bank;
        rcw_t                                            rcw;  // always nop here
        logic                                            odt_en;
        logic                                            cke;
        logic                                            sel;
        logic                                            dq_en;
        logic                                            dqs_en;
        logic                                            dqs_toggle;
        logic                                            dci;
        logic                                            buf_wr;
        logic                                            buf_rd;
        logic                                            spare;
        logic                                            buf_rst;
    } skip_fields_t;

    typedef union packed {
        cmd_fields_t  cmd;
        skip_fields_t skip; // valid when rcw decodes as nop
    } enc_word_u;

    typedef struct packed {
        logic [2:0]                   bank;
        logic [`MCONTR_ADDR_BITS-1:0] row;
        logic [`MCONTR_COL_BITS-4:0]  start_col;      // in bursts of 8 columns
        logic [`MCONTR_XFER_BITS-1:0] num128;         // bursts, 0 is 64
        logic                         skip_next_page; // keep the buffer page
    } xfer_par_t;

    typedef struct packed {
        logic      wr;   // word valid
        logic      done; // pulse after the last word
        enc_word_u word;
    } enc_out_t;

endpackage

/* cmd_encod_linear_wr.sv */
// ROM sequencer emitting the command words of a linear page write
`include "mcontr_cfg.svh"

module cmd_encod_linear_wr import mcontr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  xfer_par_t par,   // transfer setup
    input  logic      start, // one-cycle start
    output enc_out_t  enc    // encoded word stream
);
    localparam int R_BUF_RD     = 0;  // rom bit positions
    localparam int R_DQS_TOGGLE = 1;
    localparam int R_DQ_DQS_EN  = 2;
    localparam int R_SEL        = 3;
    localparam int R_ODT        = 4;
    localparam int R_CMD        = 5;  // 2 bits
    localparam int R_PAUSE      = 7;  // 2 bits
    localparam int R_PRE_DONE   = 9;
    localparam int R_PGNEXT     = 10;
    localparam int R_NOP        = 11;

    localparam logic [1:0] C_NOP   = 2'd0; // local command codes
    localparam logic [1:0] C_WRITE = 2'd1;
    localparam logic [1:0] C_PRE   = 2'd2;

    localparam logic [3:0] WRITE_ADDR1  = 4'h3;
    localparam logic [3:0] REPEAT_ADDR  = 4'h5; // loop step, one write per pass
    localparam logic [3:0] PRELAST_ADDR = 4'h6; // entry for three bursts
    localparam logic [3:0] LAST_ADDR    = 4'h8; // entry for two bursts
    localparam logic [3:0] NOWR_ADDR    = 4'ha; // entry for a single burst
    localparam logic [3:0] CUT_SINGLE   = 4'h2;
    localparam logic [3:0] CUT_DUAL     = 4'h4;

    logic                         gen_run;
    logic                         start_d;
    logic [3:0]                   gen_addr;
    logic [3:0]                   jump_addr;
    logic [11:0]                  rom_r;
    logic [`MCONTR_XFER_BITS:0]   num128;    // one more bit to hold 64
    logic                         single_write;
    logic                         dual_write;
    logic                         few_write; // 1, 2 or 3 bursts
    logic                         cut_buf_rd;
    logic [`MCONTR_COL_BITS-4:0]  col;
    xfer_par_t                    par_r;
    rcw_t                         rcw;
    enc_word_u                    word;

    wire [1:0] rom_cmd  = rom_r[R_CMD+:2];
    wire       pre_done = rom_r[R_PRE_DONE] && gen_run;
    wire       cut_next = single_write ? (gen_addr == CUT_SINGLE) :
                          (dual_write && (gen_addr == CUT_DUAL));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gen_run      <= 1'b0;
            gen_addr     <= '0;
            num128       <= '0;
            single_write <= 1'b0;
            dual_write   <= 1'b0;
            few_write    <= 1'b0;
            jump_addr    <= '0;
        end else begin
            if (start)
                gen_run <= 1'b1;
            else if (pre_done)
                gen_run <= 1'b0;
            if (!start && !gen_run)
                gen_addr <= '0;
            else if ((gen_addr == REPEAT_ADDR - 4'd1) && few_write)
                gen_addr <= jump_addr;      // short tails skip the loop
            else if ((gen_addr != REPEAT_ADDR) || (num128[`MCONTR_XFER_BITS:2] == 0))
                gen_addr <= gen_addr + 4'd1;
            if (start)
                num128 <= {par.num128 == 0, par.num128};
            else if ((gen_addr == WRITE_ADDR1) || (gen_addr == REPEAT_ADDR))
                num128 <= num128 - 1'b1;    // one per write issued
            if (start_d) begin
                single_write <= (num128[`MCONTR_XFER_BITS:1] == 0);
                dual_write   <= (num128 == 2);
                few_write    <= (num128[`MCONTR_XFER_BITS:2] == 0);
            end
            jump_addr <= single_write ? NOWR_ADDR : (dual_write ? LAST_ADDR : PRELAST_ADDR);
        end
    end

    always_ff @(posedge clk) begin
        start_d    <= start;
        cut_buf_rd <= rom_r[R_BUF_RD] && (cut_buf_rd || cut_next); // stop fetching
        if (start)
            par_r <= par;
        if (start)
            col <= par.start_col;
        else if (rom_cmd == C_WRITE)
            col <= col + 1'b1;              // next burst
    end

    // rom bits nop pgnext pre_done pause cmd odt sel dq_dqs dqs_toggle buf_rd
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_r <= '0;
        end else begin
            case (gen_addr)
                4'h0: rom_r <= 12'b0_0_0_00_11_0_0_0_0_1; // activate, start prefetch
                4'h1: rom_r <= 12'b0_0_0_00_00_0_0_0_0_1;
                4'h2: rom_r <= 12'b0_0_0_00_00_0_0_0_0_1;
                4'h3: rom_r <= 12'b0_0_0_00_01_1_1_0_0_1; // first write
                4'h4: rom_r <= 12'b0_0_0_00_00_1_0_1_0_1;
                4'h5: rom_r <= 12'b1_0_0_00_01_1_1_1_1_1; // loop write
                4'h6: rom_r <= 12'b0_0_0_00_01_1_1_1_1_1;
                4'h7: rom_r <= 12'b0_0_0_00_00_1_1_1_1_0;
                4'h8: rom_r <= 12'b0_0_0_00_01_1_1_1_1_0; // last write
                4'h9: rom_r <= 12'b0_0_0_00_00_1_0_1_1_0; // dqs tail
                4'ha: rom_r <= 12'b0_0_0_10_00_1_0_1_1_0;
                4'hb: rom_r <= 12'b0_0_0_10_00_0_0_0_0_0;
                4'hc: rom_r <= 12'b0_1_0_00_10_0_0_0_0_0; // precharge
                4'hd: rom_r <= 12'b0_0_0_10_00_0_0_0_0_0;
                4'he: rom_r <= 12'b0_0_1_00_00_0_0_0_0_0; // done
                default: rom_r <= '0;
            endcase
        end
    end

    always_comb begin
        case (rom_cmd)
            C_WRITE: rcw = RCW_WRITE;
            C_PRE:   rcw = RCW_PRECHARGE;
            C_NOP:   rcw = RCW_NOP;
            default: rcw = RCW_ACTIVATE;
        endcase
    end

    always_comb begin
        word                = '0;
        word.cmd.bank       = par_r.bank;           // same spot in both forms
        word.cmd.odt_en     = rom_r[R_ODT];
        word.cmd.sel        = rom_r[R_SEL];
        word.cmd.dq_en      = rom_r[R_DQ_DQS_EN];
        word.cmd.dqs_en     = rom_r[R_DQ_DQS_EN];
        word.cmd.dqs_toggle = rom_r[R_DQS_TOGGLE];
        word.cmd.buf_rd     = rom_r[R_BUF_RD] && !cut_buf_rd;
        word.cmd.buf_rst    = rom_r[R_PGNEXT] && !par_r.skip_next_page;
        if (rom_cmd == C_NOP) begin
            word.skip.skip = `MCONTR_PAUSE_BITS'(rom_r[R_PAUSE+:2]);
            word.skip.done = pre_done;
        end else begin
            word.cmd.rcw  = rcw;
            word.cmd.nop  = rom_r[R_NOP];
            word.cmd.addr = (rom_cmd == C_WRITE) ?
                {{(`MCONTR_ADDR_BITS-`MCONTR_COL_BITS){1'b0}}, col, 3'b000} : par_r.row;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enc <= '0;
        end else begin
            enc.wr   <= gen_run;
            enc.done <= enc.wr && !gen_run;         // one cycle after the last word
            if (gen_run)
                enc.word <= word;
        end
    end

endmodule

/* cmd_encod_linear_rd.sv */
// ROM sequencer emitting the command words of a linear page read
`include "mcontr_cfg.svh"

module cmd_encod_linear_rd import mcontr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  xfer_par_t par,   // transfer setup
    input  logic      start, // one-cycle start
    output enc_out_t  enc    // encoded word stream
);
    localparam int R_BUF_WR   = 0; // rom bit positions
    localparam int R_SEL      = 1;
    localparam int R_CMD      = 2; // 2 bits
    localparam int R_PAUSE    = 4; // 2 bits
    localparam int R_PRE_DONE = 6;
    localparam int R_PGNEXT   = 7;

    localparam logic [1:0] C_NOP  = 2'd0;
    localparam logic [1:0] C_READ = 2'd1;
    localparam logic [1:0] C_PRE  = 2'd2;

    localparam logic [2:0] LOOP_ADDR = 3'd2; // one read per pass

    logic                        gen_run;
    logic [2:0]                  gen_addr;
    logic [7:0]                  rom_r;
    logic [`MCONTR_XFER_BITS:0]  num128;
    logic [`MCONTR_COL_BITS-4:0] col;
    xfer_par_t                   par_r;
    rcw_t                        rcw;
    enc_word_u                   word;

    wire [1:0] rom_cmd  = rom_r[R_CMD+:2];
    wire       pre_done = rom_r[R_PRE_DONE] && gen_run;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gen_run  <= 1'b0;
            gen_addr <= '0;
            num128   <= '0;
        end else begin
            if (start)
                gen_run <= 1'b1;
            else if (pre_done)
                gen_run <= 1'b0;
            if (!start && !gen_run)
                gen_addr <= '0;
            else if ((gen_addr != LOOP_ADDR) || (num128 == 1))
                gen_addr <= gen_addr + 3'd1; // leave loop on the last burst
            if (start)
                num128 <= {par.num128 == 0, par.num128};
            else if (gen_addr == LOOP_ADDR)
                num128 <= num128 - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            par_r <= par;
        if (start)
            col <= par.start_col;
        else if (rom_cmd == C_READ)
            col <= col + 1'b1;
    end

    // rom bits pgnext pre_done pause cmd sel buf_wr
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_r <= '0;
        end else begin
            case (gen_addr)
                3'd0: rom_r <= 8'b0_0_00_11_0_0; // activate
                3'd1: rom_r <= 8'b0_0_10_00_0_0; // tRCD pause
                3'd2: rom_r <= 8'b0_0_00_01_1_1; // read into the buffer
                3'd3: rom_r <= 8'b0_0_11_00_0_0; // drain read latency
                3'd4: rom_r <= 8'b1_0_00_10_0_0; // precharge
                3'd5: rom_r <= 8'b0_1_00_00_0_0; // done
                default: rom_r <= '0;
            endcase
        end
    end

    always_comb begin
        case (rom_cmd)
            C_READ:  rcw = RCW_READ;
            C_PRE:   rcw = RCW_PRECHARGE;
            C_NOP:   rcw = RCW_NOP;
            default: rcw = RCW_ACTIVATE;
        endcase
    end

    always_comb begin
        word             = '0;
        word.cmd.bank    = par_r.bank;
        word.cmd.sel     = rom_r[R_SEL];
        word.cmd.buf_wr  = rom_r[R_BUF_WR];   // dq and dqs stay tristate
        word.cmd.buf_rst = rom_r[R_PGNEXT] && !par_r.skip_next_page;
        if (rom_cmd == C_NOP) begin
            word.skip.skip = `MCONTR_PAUSE_BITS'(rom_r[R_PAUSE+:2]);
            word.skip.done = pre_done;
        end else begin
            word.cmd.rcw  = rcw;
            word.cmd.addr = (rom_cmd == C_READ) ?
                {{(`MCONTR_ADDR_BITS-`MCONTR_COL_BITS){1'b0}}, col, 3'b000} : par_r.row;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enc <= '0;
        end else begin
            enc.wr   <= gen_run;
            enc.done <= enc.wr && !gen_run;
            if (gen_run)
                enc.word <= word;
        end
    end

endmodule

/* cmd_seq_writer.sv */
// sequence memory writer merging both encoder streams, with length and completion status
`include "mcontr_cfg.svh"

module cmd_seq_writer import mcontr_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,     // either start pulse
    input  enc_out_t                  wr_enc,
    input  enc_out_t                  rd_enc,
    input  logic [`MCONTR_SEQ_AW-1:0] seq_raddr,
    output enc_word_u                 seq_rdata,
    output logic                      busy,
    output logic                      done,      // sticky until next start
    output logic [`MCONTR_SEQ_AW:0]   seq_len
);
    enc_word_u               mem [`MCONTR_SEQ_DEPTH];
    logic [`MCONTR_SEQ_AW:0] wptr;   // top bit marks a full memory

    wire       any_wr   = wr_enc.wr || rd_enc.wr;   // one encoder at a time
    wire       any_done = wr_enc.done || rd_enc.done;
    wire       store    = any_wr && !wptr[`MCONTR_SEQ_AW]; // drop words past the end
    enc_word_u in_word;

    assign in_word   = wr_enc.wr ? wr_enc.word : rd_enc.word;
    assign seq_rdata = mem[seq_raddr];
    assign seq_len   = wptr;

    always_ff @(posedge clk) begin
        if (store)
            mem[wptr[`MCONTR_SEQ_AW-1:0]] <= in_word;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            if (start)
                wptr <= '0;
            else if (store)
                wptr <= wptr + 1'b1;
            if (start)
                busy <= 1'b1;
            else if (any_done)
                busy <= 1'b0;
            if (start)
                done <= 1'b0;
            else if (any_done)
                done <= 1'b1;
        end
    end

endmodule

/* mcontr_apb_regs.sv */
// APB slave with transfer registers, start pulses, status and sequence memory readback
`include "mcontr_cfg.svh"

module mcontr_apb_regs import mcontr_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [11:0]               paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    input  logic                      busy,
    input  logic                      done,
    input  logic [`MCONTR_SEQ_AW:0]   seq_len,
    input  enc_word_u                 seq_rdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output xfer_par_t                 par,
    output logic                      start_wr,
    output logic                      start_rd,
    output logic [`MCONTR_SEQ_AW-1:0] seq_raddr
);
    localparam logic [11:0] A_CTRL    = 12'h000;
    localparam logic [11:0] A_BANKROW = 12'h004;
    localparam logic [11:0] A_XFER    = 12'h008;
    localparam logic [11:0] A_STATUS  = 12'h00C;

    logic bad_addr;

    wire acc     = psel && penable;          // access phase
    wire is_seq  = (paddr[11:8] == 4'h1);    // 0x100 to 0x1FC
    wire is_ctrl = acc && pwrite && (paddr == A_CTRL);
    wire busy_any = busy || start_wr || start_rd; // pulse in flight counts too
    wire refuse  = is_ctrl && (pwdata[1:0] != 2'b00) && (busy_any || (&pwdata[1:0]));

    assign pready    = 1'b1;
    assign pslverr   = acc && (bad_addr || refuse);
    assign seq_raddr = paddr[`MCONTR_SEQ_AW+1:2];

    always_comb begin
        if (pwrite)
            bad_addr = !((paddr == A_CTRL) || (paddr == A_BANKROW) || (paddr == A_XFER));
        else
            bad_addr = !((paddr == A_BANKROW) || (paddr == A_XFER) ||
                         (paddr == A_STATUS) || is_seq);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_wr <= 1'b0;
            start_rd <= 1'b0;
            par      <= '0;
        end else begin
            start_wr <= is_ctrl && !refuse && pwdata[0];
            start_rd <= is_ctrl && !refuse && pwdata[1];
            if (acc && pwrite && (paddr == A_BANKROW)) begin
                par.row  <= pwdata[`MCONTR_ADDR_BITS-1:0];
                par.bank <= pwdata[18:16];
            end
            if (acc && pwrite && (paddr == A_XFER)) begin
                par.start_col      <= pwdata[`MCONTR_COL_BITS-4:0];
                par.num128         <= pwdata[8+:`MCONTR_XFER_BITS];
                par.skip_next_page <= pwdata[16];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (is_seq) begin
            prdata = seq_rdata;
        end else begin
            case (paddr)
                A_BANKROW: begin
                    prdata[`MCONTR_ADDR_BITS-1:0] = par.row;
                    prdata[18:16]                 = par.bank;
                end
                A_XFER: begin
                    prdata[`MCONTR_COL_BITS-4:0]  = par.start_col;
                    prdata[8+:`MCONTR_XFER_BITS]  = par.num128;
                    prdata[16]                    = par.skip_next_page;
                end
                A_STATUS: begin
                    prdata[0]                     = busy;
                    prdata[1]                     = done;
                    prdata[8+:`MCONTR_SEQ_AW+1]   = seq_len;
                end
                default: prdata = '0;
            endcase
        end
    end

endmodule

/* mcontr_seq_top.sv */
// top level joining the APB registers, both encoders and the sequence writer
`include "mcontr_cfg.svh"

module mcontr_seq_top import mcontr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    xfer_par_t                 par;
    logic                      start_wr;
    logic                      start_rd;
    enc_out_t                  wr_enc;
    enc_out_t                  rd_enc;
    logic                      busy;
    logic                      done;
    logic [`MCONTR_SEQ_AW:0]   seq_len;
    logic [`MCONTR_SEQ_AW-1:0] seq_raddr;
    enc_word_u                 seq_rdata;

    mcontr_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .busy      (busy),
        .done      (done),
        .seq_len   (seq_len),
        .seq_rdata (seq_rdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .par       (par),
        .start_wr  (start_wr),
        .start_rd  (start_rd),
        .seq_raddr (seq_raddr)
    );

    cmd_encod_linear_wr u_enc_wr (
        .clk   (clk),
        .rst   (rst),
        .par   (par),
        .start (start_wr),
        .enc   (wr_enc)
    );

    cmd_encod_linear_rd u_enc_rd (
        .clk   (clk),
        .rst   (rst),
        .par   (par),
        .start (start_rd),
        .enc   (rd_enc)
    );

    cmd_seq_writer u_seq_writer (
        .clk       (clk),
        .rst       (rst),
        .start     (start_wr | start_rd), // restart the write pointer
        .wr_enc    (wr_enc),
        .rd_enc    (rd_enc),
        .seq_raddr (seq_raddr),
        .seq_rdata (seq_rdata),
        .busy      (busy),
        .done      (done),
        .seq_len   (seq_len)
    );

endmodule

/* tb_mcontr_seq.sv */
// directed testbench with APB driver, expected sequence model and sequence checks
`include "mcontr_cfg.svh"

module tb_mcontr_seq import mcontr_pkg::*; ();
    localparam int CLK_HALF    = 4;
    localparam int CYCLE_LIMIT = 10 * 80 * 25; // transfers x longest sequence x apb overhead
    localparam int POLL_LIMIT  = 200;          // status reads before a hang is declared
    localparam int PAGE_BURSTS = 1 << (`MCONTR_COL_BITS - 3); // bursts of 8 columns in a row

    localparam logic [11:0] REG_CTRL    = 12'h000;
    localparam logic [11:0] REG_BANKROW = 12'h004;
    localparam logic [11:0] REG_XFER    = 12'h008;
    localparam logic [11:0] REG_STATUS  = 12'h00C;
    localparam logic [11:0] REG_SEQ     = 12'h100;

    logic        clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int     errors;
    int     checks;
    int     cycles;
    integer seed;

    logic [2:0]                   exp_bank;    // expected transfer from build_expected
    logic [`MCONTR_ADDR_BITS-1:0] exp_row;
    logic                         exp_buf_rst;
    int                           exp_bursts;
    logic [`MCONTR_ADDR_BITS-1:0] exp_addr [$]; // column address of each burst

    mcontr_seq_top u_mcontr_seq (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // starts and ends on a falling edge
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        paddr   = addr;    // setup phase
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;    // access phase
        #1;
        err = pslverr;     // settled before the rising edge
        check_val("pready", 1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // expected row, bank, buffer reset and the column of each burst within the page
    task automatic build_expected(input logic [2:0] bank, input logic [14:0] row,
                                  input logic [6:0] start_col, input logic [5:0] num128,
                                  input logic skip_page);
        int k;
        exp_bank    = bank;
        exp_row     = row;
        exp_buf_rst = !skip_page;
        exp_bursts  = (num128 == 0) ? 64 : num128; // 0 is a full page
        exp_addr.delete();
        for (k = 0; k < exp_bursts; k++)
            exp_addr.push_back(`MCONTR_ADDR_BITS'(((start_col + k) % PAGE_BURSTS) * 8));
    endtask

    task automatic wait_done(output logic ok);
        logic [31:0] st;
        logic        err;
        int          n;
        ok = 1'b0;
        n  = 0;
        while (!ok && (n < POLL_LIMIT)) begin
            apb_read(REG_STATUS, st, err);
            ok = st[1];
            n++;
        end
        if (!ok) begin
            errors++;
            $display("done flag never came after %0d status reads, the sequence hung",
                     POLL_LIMIT);
        end
    endtask

    // reads the stored words back and checks them against the expected transfer
    task automatic check_sequence(input logic is_read, input logic capped);
        logic [31:0] st;
        logic [31:0] data;
        logic        err;
        enc_word_u   w;
        rcw_t        data_rcw;
        int          len;
        int          i;
        int          n_data;
        int          n_pre;
        apb_read(REG_STATUS, st, err);
        check_val("status.busy", 1'b0, st[0]);
        check_val("status.done", 1'b1, st[1]);
        len = st[14:8];
        if (capped)
            check_val("status.seq_len", `MCONTR_SEQ_DEPTH, len); // long page cut at depth
        data_rcw = is_read ? RCW_READ : RCW_WRITE;
        n_data   = 0;
        n_pre    = 0;
        data     = '0;
        for (i = 0; i < len; i++) begin
            apb_read(REG_SEQ + 12'(i * 4), data, err);
            check_val($sformatf("seq[%0d].pslverr", i), 1'b0, err);
            w = data;
            if (i == 0) begin
                check_val("seq[0].rcw", RCW_ACTIVATE, w.cmd.rcw);
                check_val("seq[0].addr", exp_row, w.cmd.addr);
                check_val("seq[0].bank", exp_bank, w.cmd.bank);
            end else if (w.cmd.rcw == data_rcw) begin
                if (n_data < exp_bursts)
                    check_val($sformatf("seq[%0d].addr", i), exp_addr[n_data], w.cmd.addr);
                if (is_read) begin          // data lands in the page buffer
                    check_val($sformatf("seq[%0d].dq_en", i), 1'b0, w.cmd.dq_en);
                    check_val($sformatf("seq[%0d].dqs_en", i), 1'b0, w.cmd.dqs_en);
                    check_val($sformatf("seq[%0d].buf_wr", i), 1'b1, w.cmd.buf_wr);
                end
                n_data++;
            end else if (w.cmd.rcw == RCW_PRECHARGE) begin
                check_val($sformatf("seq[%0d].buf_rst", i), exp_buf_rst, w.cmd.buf_rst);
                n_pre++;
            end else if (w.cmd.rcw == RCW_NOP) begin
                if (i != len - 1)
                    check_val($sformatf("seq[%0d].done", i), 1'b0, w.skip.done);
            end else begin
                errors++;
                $display("word %0d holds command code %0d, not allowed in this sequence",
                         i, w.cmd.rcw);
            end
        end
        if (capped) begin
            if ((n_data == 0) || (n_data > exp_bursts)) begin
                errors++;
                $display("cut sequence holds %0d data commands, expected 1 to %0d",
                         n_data, exp_bursts);
            end
        end else begin
            check_val(is_read ? "read_count" : "write_count", exp_bursts, n_data);
            check_val("precharge_count", 1, n_pre);
            w = data;                       // last word read
            check_val("last.rcw", RCW_NOP, w.cmd.rcw);
            check_val("last.done", 1'b1, w.skip.done);
        end
    endtask

    task automatic program_xfer(input logic [2:0] bank, input logic [14:0] row,
                                input logic [6:0] start_col, input logic [5:0] num128,
                                input logic skip_page);
        logic err;
        apb_write(REG_BANKROW, {13'b0, bank, 1'b0, row}, err);
        check_val("bankrow.pslverr", 1'b0, err);
        apb_write(REG_XFER, {15'b0, skip_page, 2'b0, num128, 1'b0, start_col}, err);
        check_val("xfer.pslverr", 1'b0, err);
        build_expected(bank, row, start_col, num128, skip_page);
    endtask

    task automatic run_xfer(input logic is_read, input logic [2:0] bank, input logic [14:0] row,
                            input logic [6:0] start_col, input logic [5:0] num128,
                            input logic skip_page);
        logic err;
        logic ok;
        program_xfer(bank, row, start_col, num128, skip_page);
        apb_write(REG_CTRL, is_read ? 32'h2 : 32'h1, err);
        check_val("start.pslverr", 1'b0, err);
        wait_done(ok);
        if (ok)
            check_sequence(is_read, num128 == 0);
    endtask

    task automatic after_reset_status();
        logic [31:0] st;
        logic        err;
        apb_read(REG_STATUS, st, err);
        check_val("status.pslverr", 1'b0, err);
        check_val("status.busy", 1'b0, st[0]);
        check_val("status.done", 1'b0, st[1]);
        check_val("status.seq_len", 0, st[14:8]);
        apb_read(12'h010, st, err);         // hole in the register map
        check_val("unmapped.pslverr", 1'b1, err);
    endtask

    task automatic write_burst_counts();
        run_xfer(1'b0, 3'd1, 15'h1234, 7'd10, 6'd1, 1'b0);
        run_xfer(1'b0, 3'd2, 15'h0abc, 7'd127, 6'd2, 1'b0); // wraps on the second burst
        run_xfer(1'b0, 3'd5, 15'h7fff, 7'd0, 6'd3, 1'b0);
        run_xfer(1'b0, 3'd7, 15'h2468, 7'd40, 6'd5, 1'b0);
    endtask

    task automatic random_read();
        logic [5:0] num;
        logic [6:0] col;
        num = ($random(seed) & 31) + 1;    // short enough to fit the memory
        col = $random(seed) & 127;
        run_xfer(1'b1, 3'd3, 15'h0f0f, col, num, 1'b0);
    endtask

    task automatic page_keep_xfers();
        run_xfer(1'b0, 3'd4, 15'h0101, 7'd7, 6'd4, 1'b1);
        run_xfer(1'b1, 3'd6, 15'h0202, 7'd9, 6'd3, 1'b1);
    endtask

    task automatic full_page_xfers();
        run_xfer(1'b0, 3'd0, 15'h3333, 7'd100, 6'd0, 1'b0);
        run_xfer(1'b1, 3'd2, 15'h4444, 7'd100, 6'd0, 1'b0);
    endtask

    task automatic busy_start_refusal();
        logic err;
        logic ok;
        program_xfer(3'd5, 15'h5555, 7'd20, 6'd6, 1'b0);
        apb_write(REG_CTRL, 32'h1, err);
        check_val("start.pslverr", 1'b0, err);
        apb_write(REG_CTRL, 32'h2, err);   // read start while the write runs
        check_val("busy_start.pslverr", 1'b1, err);
        wait_done(ok);
        if (ok)
            check_sequence(1'b0, 1'b0);
    endtask

    initial begin
        seed    = 32'h98c0d8ec;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        after_reset_status();
        write_burst_counts();
        random_read();
        page_keep_xfers();
        full_page_xfers();
        busy_start_refusal();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
mcontr_pkg.sv
cmd_encod_linear_wr.sv
cmd_encod_linear_rd.sv
cmd_seq_writer.sv
mcontr_apb_regs.sv
mcontr_seq_top.sv
tb_mcontr_seq.sv
